/* bench/mcycleInput.dat */
// op(0 mul, 1 div) operand1 operand2 wa3 expected, all hex
// Multiply gives the low product word, divide the quotient
0 00000003 00000007 1 00000015
0 00000000 12345678 2 00000000
0 FFFFFFFF FFFFFFFF 3 00000001
0 0000FFFF 0000FFFF 4 FFFE0001
0 12345678 00000010 5 23456780
0 80000000 00000002 6 00000000
0 DEADBEEF 00000001 7 DEADBEEF
0 00010000 00010000 8 00000000
0 00000007 00000006 9 0000002A
0 FFFFFFFF 00000002 A FFFFFFFE
// Divide vectors
1 0000000A 00000003 B 00000003
1 00000003 0000000A C 00000000
1 FFFFFFFF FFFFFFFF D 00000001
1 FFFFFFFF 00000001 E FFFFFFFF
1 FFFFFFFF 00000002 F 7FFFFFFF
1 80000000 00000010 0 08000000
1 12345678 12345679 1 00000000
1 00000064 00000007 2 0000000E
1 FFFFFFFE FFFFFFFF 3 00000000
1 00000000 00000005 4 00000000
// Divide by zero
1 12345678 00000000 5 FFFFFFFF
1 00000000 00000000 6 FFFFFFFF

/* compile.f */
+incdir+bench
common/mcyclePkg.sv
hdl/mcycleDecode.sv
mcycleExec/mcycleControl.sv
mcycleExec/mcycleIterate.sv
hdl/mcycleWriteback.sv
hdl/mcycleTop.sv
bench/mcycleTb.sv

/* bench/mcycleChecks.svh */
`ifndef MCYCLECHECKS_SVH
`define MCYCLECHECKS_SVH

////////////////////////////////////////
// Random numbers
////////////////////////////////////////

logic [31:0] rngState = 32'd65;

// Full period 32-bit LCG
function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic checkResult(
    input string            name,
    input logic [Width-1:0] expected,
    input logic [Width-1:0] actual
);
    if (actual !== expected) begin
        $display("[ERROR] %s: result expected %h, actual %h", name, expected, actual);
        errorCount++;
    end
endtask

task automatic checkWa3(
    input string              name,
    input mcyclePkg::regAddrT expected,
    input mcyclePkg::regAddrT actual
);
    if (actual !== expected) begin
        $display("[ERROR] %s: wa3 expected %h, actual %h", name, expected, actual);
        errorCount++;
    end
endtask

// Single status bits such as Busy and the push
task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("[ERROR] %s: flag expected %b, actual %b", name, expected, actual);
        errorCount++;
    end
endtask

`endif

/* bench/mcycleTb.sv */
`timescale 1ns/100ps

module mcycleTb;

    localparam int Width = 32;

    logic                CLK = 1'b0;
    logic                Reset;
    logic                Start;
    mcyclePkg::mcycleOpE Op;
    logic [Width-1:0]    Operand1;
    logic [Width-1:0]    Operand2;
    mcyclePkg::regAddrT  Wa3;
    logic [Width-1:0]    Result;
    mcyclePkg::wbTagS    Wb;
    logic                Busy;

    int errorCount = 0;
    int passCount  = 0;
    int failCount  = 0;

    `include "mcycleChecks.svh"

    mcycleTop #(.Width(Width)) dut (
        .CLK(CLK), .Reset(Reset), .Start(Start), .Op(Op), .Operand1(Operand1),
        .Operand2(Operand2), .Wa3(Wa3), .Result(Result), .Wb(Wb), .Busy(Busy)
    );

    always #2 CLK = ~CLK;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Low product word, or quotient with all ones on a zero divisor
    function automatic logic [Width-1:0] computeExpected(input mcyclePkg::mcycleOpE op,
            input logic [Width-1:0] a, input logic [Width-1:0] b);
        if (op == mcyclePkg::opMul) begin
            return a * b;
        end else if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    task automatic reportTest(input string name, input int errBefore);
        if (errorCount == errBefore) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s", name);
        end
    endtask

    // One-cycle Start strobe
    task automatic issueStart(input mcyclePkg::mcycleOpE op, input logic [Width-1:0] a,
            input logic [Width-1:0] b, input mcyclePkg::regAddrT wa3);
        @(posedge CLK);
        Start    <= 1'b1;
        Op       <= op;
        Operand1 <= a;
        Operand2 <= b;
        Wa3      <= wa3;
        @(posedge CLK);
        Start <= 1'b0;
    endtask

    task automatic waitForPush(input string name, output logic ok);
        ok = 1'b0;
        for (int i = 0; i < 2 * Width && !ok; i++) begin
            @(negedge CLK);
            ok = Wb.push;
        end
        if (!ok) begin
            $display("%s: the write-back push never came (control state %0d)",
                name, dut.exec.control.state);
            errorCount++;
        end
    endtask

    // Level wait on Busy, high or low
    task automatic waitForBusy(input string name, input logic level, output logic ok);
        ok = 1'b0;
        for (int i = 0; i < 2 * Width && !ok; i++) begin
            @(negedge CLK);
            ok = (Busy == level);
        end
        if (!ok) begin
            $display("%s: Busy never went to %b (control state %0d)",
                name, level, dut.exec.control.state);
            errorCount++;
        end
    endtask

    task automatic runRequest(input string name, input mcyclePkg::mcycleOpE op,
            input logic [Width-1:0] a, input logic [Width-1:0] b,
            input mcyclePkg::regAddrT wa3, input logic [Width-1:0] expected);
        int   errBefore;
        logic ok;
        errBefore = errorCount;
        waitForBusy(name, 1'b0, ok);
        if (ok) begin
            issueStart(op, a, b, wa3);
            waitForPush(name, ok);
            if (ok) begin
                checkResult(name, expected, Result);
                checkWa3(name, wa3, Wb.wa3);
            end
        end
        reportTest(name, errBefore);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    int                  fd;
    int                  fields;
    int                  vecCount = 0;
    int                  errBefore;
    logic                ok;
    logic [8*160-1:0]    lineBuf;
    logic [3:0]          vecOp;
    logic [Width-1:0]    vecA;
    logic [Width-1:0]    vecB;
    logic [3:0]          vecWa3;
    logic [Width-1:0]    vecExp;
    logic [31:0]         r;
    mcyclePkg::mcycleOpE randOp;
    logic [Width-1:0]    randA;
    logic [Width-1:0]    randB;

    initial begin
        Reset    <= 1'b1;
        Start    <= 1'b0;
        Op       <= mcyclePkg::opMul;
        Operand1 <= '0;
        Operand2 <= '0;
        Wa3      <= '0;
        repeat (5) @(posedge CLK);
        Reset <= 1'b0;

        // State right after reset
        @(negedge CLK);
        errBefore = errorCount;
        checkFlag("reset busy", 1'b0, Busy);
        checkFlag("reset push", 1'b0, Wb.push);
        checkResult("reset result", '0, Result);
        reportTest("reset state", errBefore);

        // Directed vectors from the data file
        fd = $fopen("bench/mcycleInput.dat", "r");
        if (fd == 0) begin
            $display("Could not open the vector file bench/mcycleInput.dat");
            failCount++;
        end else begin
            while (!$feof(fd)) begin
                lineBuf = '0;
                if ($fgets(lineBuf, fd) > 0) begin
                    fields = $sscanf(lineBuf, "%h %h %h %h %h",
                        vecOp, vecA, vecB, vecWa3, vecExp);
                    if (fields == 5) begin
                        vecCount++;
                        runRequest($sformatf("%s vector %0d", vecOp[0] ? "div" : "mul",
                            vecCount), mcyclePkg::mcycleOpE'(vecOp[0]), vecA, vecB,
                            vecWa3, vecExp);
                    end
                end
            end
            $fclose(fd);
            if (vecCount == 0) begin
                $display("No vectors were read from bench/mcycleInput.dat");
                failCount++;
            end
        end

        // Random operands, divisors shortened for varied quotients
        for (int i = 0; i < 20; i++) begin
            r      = nextRandom();
            randA  = nextRandom();
            randB  = nextRandom();
            randOp = r[31] ? mcyclePkg::opDiv : mcyclePkg::opMul;
            if (randOp == mcyclePkg::opDiv) begin
                randB = randB >> r[8:4];
            end
            runRequest($sformatf("random %0d", i), randOp, randA, randB, r[3:0],
                computeExpected(randOp, randA, randB));
        end

        // Second Start on the last busy cycle must be dropped
        errBefore = errorCount;
        issueStart(mcyclePkg::opMul, 32'd6, 32'd7, 4'd3);
        // Done cycle sits Width+2 edges after the edge that took Start
        repeat (Width + 2) @(posedge CLK);
        Start    <= 1'b1;
        Op       <= mcyclePkg::opDiv;
        Operand1 <= 32'd100;
        Operand2 <= 32'd5;
        Wa3      <= 4'd9;
        @(negedge CLK);
        checkFlag("dropped start busy", 1'b1, Busy);
        @(posedge CLK);
        Start <= 1'b0;
        waitForPush("dropped start", ok);
        if (ok) begin
            checkResult("dropped start", 32'd42, Result);
            checkWa3("dropped start", 4'd3, Wb.wa3);
            for (int i = 0; i < 2 * Width; i++) begin
                @(negedge CLK);
                if (Wb.push) begin
                    $display("dropped start: an unexpected second push came");
                    errorCount++;
                end
            end
        end
        reportTest("dropped start", errBefore);

        // Back-to-back requests
        runRequest("back-to-back 0", mcyclePkg::opMul, 32'd1000, 32'd1000, 4'd1, 32'd1000000);
        runRequest("back-to-back 1", mcyclePkg::opDiv, 32'd1000000, 32'd999, 4'd2, 32'd1001);
        runRequest("back-to-back 2", mcyclePkg::opDiv, 32'd77, 32'd0, 4'd14, 32'hFFFFFFFF);
        runRequest("back-to-back 3", mcyclePkg::opMul, 32'h00012345, 32'd3, 4'd15,
            32'h000369CF);

        $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Whole-run watchdog
    initial begin
        #200000;
        $display("Simulation ran out of time before all tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* hdl/mcycleTop.sv */
`timescale 1ns/100ps

// Multicycle multiply/divide unit
module mcycleTop #(
    parameter int Width = 32
) (
    input  logic                CLK,
    input  logic                Reset,
    input  logic                Start,
    input  mcyclePkg::mcycleOpE Op,
    input  logic [Width-1:0]    Operand1,
    input  logic [Width-1:0]    Operand2,
    input  mcyclePkg::regAddrT  Wa3,
    output logic [Width-1:0]    Result,
    output mcyclePkg::wbTagS    Wb,
    output logic                Busy
);

    logic                 reqValid;
    mcyclePkg::mcycleTagS reqTag;
    logic [Width-1:0]     reqA;
    logic [Width-1:0]     reqB;
    logic                 done;
    logic [Width-1:0]     execResult;
    mcyclePkg::regAddrT   execWa3;

    mcycleDecode #(.Width(Width)) decode (
        .CLK     (CLK),
        .Reset   (Reset),
        .Start   (Start),
        .Op      (Op),
        .Operand1(Operand1),
        .Operand2(Operand2),
        .Wa3     (Wa3),
        .Busy    (Busy),
        .ReqValid(reqValid),
        .ReqTag  (reqTag),
        .ReqA    (reqA),
        .ReqB    (reqB)
    );

    mcycleIterate #(.Width(Width)) exec (
        .CLK(CLK), .Reset(Reset), .ReqValid(reqValid), .ReqTag(reqTag),
        .ReqA(reqA), .ReqB(reqB), .Busy(Busy), .Done(done),
        .ExecResult(execResult), .ExecWa3(execWa3)
    );

    mcycleWriteback #(.Width(Width)) writeback (
        .CLK(CLK), .Reset(Reset), .Done(done), .ExecResult(execResult),
        .ExecWa3(execWa3), .Result(Result), .Wb(Wb)
    );

endmodule

/* hdl/mcycleWriteback.sv */
`timescale 1ns/100ps

// Result stage toward the register file write port
module mcycleWriteback #(
    parameter int Width = 32
) (
    input  logic               CLK,
    input  logic               Reset,
    input  logic               Done,
    input  logic [Width-1:0]   ExecResult,
    input  mcyclePkg::regAddrT ExecWa3,
    output logic [Width-1:0]   Result,
    output mcyclePkg::wbTagS   Wb
);

    logic               pushReg;
    logic [Width-1:0]   resultReg;
    mcyclePkg::regAddrT wa3Reg;

    ////////////////////////////////////////
    // Push strobe
    ////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            pushReg <= 1'b0;
        end else begin
            pushReg <= Done;
        end
    end

    ////////////////////////////////////////
    // Result latch
    ////////////////////////////////////////

    // Holds until the next completed operation
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            resultReg <= '0;
            wa3Reg    <= '0;
        end else if (Done) begin
            resultReg <= ExecResult;
            wa3Reg    <= ExecWa3;
        end
    end

    assign Result  = resultReg;
    assign Wb.push = pushReg;
    assign Wb.wa3  = wa3Reg;

    // Register file sees one write per operation
    assert property (@(posedge CLK) disable iff (Reset)
        pushReg |=> !pushReg)
    else $error("Write-back push held for two cycles");

endmodule

/* mcycleExec/mcycleIterate.sv */
`timescale 1ns/100ps

// Shift-and-add multiply and restoring divide datapath
module mcycleIterate #(
    parameter int Width = 32
) (
    input  logic                 CLK,
    input  logic                 Reset,
    input  logic                 ReqValid,
    input  mcyclePkg::mcycleTagS ReqTag,
    input  logic [Width-1:0]     ReqA,
    input  logic [Width-1:0]     ReqB,
    output logic                 Busy,
    output logic                 Done,
    output logic [Width-1:0]     ExecResult,
    output mcyclePkg::regAddrT   ExecWa3
);

    logic init;
    logic shift;
    logic write;
    logic decide;

    mcyclePkg::mcycleOpE opReg;
    logic                isDiv;
    logic                initDiv;

    // Upper half is the partial product or remainder, lower half the
    // multiplier or dividend/quotient bits
    logic [2*Width-1:0] acc;
    logic [Width-1:0]   opShift;
    mcyclePkg::regAddrT wa3Reg;

    logic [Width-1:0] addA;
    logic [Width-1:0] addB;
    logic [Width:0]   sumFull;
    logic [Width-1:0] sum;
    logic             carryOut;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    mcycleControl #(
        .Width(Width)
    ) control (
        .CLK     (CLK),
        .Reset   (Reset),
        .ReqValid(ReqValid),
        .Decide  (decide),
        .Init    (init),
        .Shift   (shift),
        .Write   (write),
        .Busy    (Busy),
        .Done    (Done)
    );

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            opReg <= mcyclePkg::opMul;
        end else if (init) begin
            opReg <= ReqTag.op;
        end
    end

    assign isDiv   = (opReg == mcyclePkg::opDiv);
    assign initDiv = (ReqTag.op == mcyclePkg::opDiv);

    ////////////////////////////////////////
    // Carry adder
    ////////////////////////////////////////

    // Divide compares the remainder after its left shift
    assign addA = isDiv ? acc[2*Width-2 -: Width] : acc[2*Width-1 -: Width];
    // Subtract as invert plus carry-in
    assign addB = isDiv ? ~opShift : opShift;

    assign sumFull  = {1'b0, addA} + {1'b0, addB} + {{Width{1'b0}}, isDiv};
    assign sum      = sumFull[Width-1:0];
    assign carryOut = sumFull[Width];

    // No borrow, or a remainder bit shifted past the top, means subtract
    assign decide = isDiv ? (carryOut | acc[2*Width-1]) : acc[0];

    ////////////////////////////////////////
    // Accumulator step
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (init) begin
            acc     <= {{Width{1'b0}}, initDiv ? ReqA : ReqB};
            opShift <= initDiv ? ReqB : ReqA;
            wa3Reg  <= ReqTag.wa3;
        end else if (shift) begin
            if (!isDiv) begin
                // Multiply, shift right with optional add
                if (write) begin
                    acc <= {carryOut, sum, acc[Width-1:1]};
                end else begin
                    acc <= {1'b0, acc[2*Width-1:1]};
                end
            end else begin
                // Divide, shift left and set quotient bit on subtract
                if (write) begin
                    acc <= {sum, acc[Width-2:0], 1'b1};
                end else begin
                    acc <= {acc[2*Width-2:0], 1'b0};
                end
            end
        end
    end

    assign ExecResult = acc[Width-1:0];
    assign ExecWa3    = wa3Reg;

endmodule

/* mcycleExec/mcycleControl.sv */
`timescale 1ns/100ps

// Sequencer for the iterative multiply/divide datapath
module mcycleControl #(
    parameter int Width = 32
) (
    input  logic CLK,
    input  logic Reset,
    input  logic ReqValid,
    input  logic Decide,
    output logic Init,
    output logic Shift,
    output logic Write,
    output logic Busy,
    output logic Done
);

    localparam int CntW = $clog2(Width);
    localparam logic [CntW-1:0] LastCnt = CntW'(Width - 1);

    mcyclePkg::ctrlStateE state;
    mcyclePkg::ctrlStateE nextState;
    logic [CntW-1:0]      iterCnt;

    ////////////////////////////////////////
    // State register and counter
    ////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state   <= mcyclePkg::stIdle;
            iterCnt <= '0;
        end else begin
            state <= nextState;
            // Counter restarts on the way into the run phase
            if (state == mcyclePkg::stInit) begin
                iterCnt <= '0;
            end else if (state == mcyclePkg::stRun) begin
                iterCnt <= iterCnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            mcyclePkg::stIdle: begin
                if (ReqValid) begin
                    nextState = mcyclePkg::stInit;
                end
            end
            mcyclePkg::stInit: begin
                nextState = mcyclePkg::stRun;
            end
            mcyclePkg::stRun: begin
                // One step per clock, Width steps in all
                if (iterCnt == LastCnt) begin
                    nextState = mcyclePkg::stDone;
                end
            end
            mcyclePkg::stDone: begin
                nextState = mcyclePkg::stIdle;
            end
            default: begin
                nextState = mcyclePkg::stIdle;
            end
        endcase
    end

    ////////////////////////////////////////
    // Datapath strobes
    ////////////////////////////////////////

    // Operands load on the edge that leaves idle
    assign Init  = (state == mcyclePkg::stIdle) && ReqValid;
    assign Shift = (state == mcyclePkg::stRun);
    // Keep the adder result only when the datapath asks for it
    assign Write = (state == mcyclePkg::stRun) && Decide;
    assign Busy  = (state != mcyclePkg::stIdle);
    assign Done  = (state == mcyclePkg::stDone);

    // Every step needs a known add-or-shift decision from the datapath
    assert property (@(posedge CLK) disable iff (Reset)
        Shift |-> !$isunknown(Decide))
    else $error("Decide unknown during an iteration step");

endmodule

/* hdl/mcycleDecode.sv */
`timescale 1ns/100ps

// Request capture stage of the multiply/divide unit
module mcycleDecode #(
    parameter int Width = 32
) (
    input  logic                 CLK,
    input  logic                 Reset,
    input  logic                 Start,
    input  mcyclePkg::mcycleOpE  Op,
    input  logic [Width-1:0]     Operand1,
    input  logic [Width-1:0]     Operand2,
    input  mcyclePkg::regAddrT   Wa3,
    input  logic                 Busy,
    output logic                 ReqValid,
    output mcyclePkg::mcycleTagS ReqTag,
    output logic [Width-1:0]     ReqA,
    output logic [Width-1:0]     ReqB
);

    logic accept;

    // Start is dropped while execute works or a request is still pending
    assign accept = Start && !Busy && !ReqValid;

    ////////////////////////////////////////
    // Request strobe
    ////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            ReqValid <= 1'b0;
        end else begin
            ReqValid <= accept;
        end
    end

    ////////////////////////////////////////
    // Captured request
    ////////////////////////////////////////

    // Held until the next accepted Start
    always_ff @(posedge CLK) begin
        if (accept) begin
            ReqTag.op  <= Op;
            ReqTag.wa3 <= Wa3;
            ReqA       <= Operand1;
            ReqB       <= Operand2;
        end
    end

    // Execute must be idle whenever a request is handed over
    assert property (@(posedge CLK) disable iff (Reset)
        !(ReqValid && Busy))
    else $error("Request issued while execute is busy");

endmodule

/* common/mcyclePkg.sv */
// Shared types for the multicycle multiply/divide unit

package mcyclePkg;

    ////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////

    // Operation select
    typedef enum logic {
        opMul = 1'b0,
        opDiv = 1'b1
    } mcycleOpE;

    // Execute control states
    typedef enum logic [1:0] {
        stIdle = 2'd0,
        stInit = 2'd1,
        stRun  = 2'd2,
        stDone = 2'd3
    } ctrlStateE;

    // Register file write address
    typedef logic [3:0] regAddrT;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////

    // Request tag from decode to execute
    typedef struct packed {
        mcycleOpE op;
        regAddrT  wa3;
    } mcycleTagS;

    // Write-back toward the register file
    typedef struct packed {
        logic    push;
        regAddrT wa3;
    } wbTagS;

endpackage
